/* source/pack_pkg.sv */
////////////////////////////////////////
// shared widths and controller states
// for the byte repacker
////////////////////////////////////////

package pack_pkg;

  // byte lanes of one input word
  localparam int IN_BYTES = 4;

  // bytes per output word
  localparam int OUT_BYTES = 4;

  // deepest possible buffer fill
  localparam int BUF_BYTES = IN_BYTES + OUT_BYTES - 1;

  // fill level width, holds 0..BUF_BYTES
  localparam int CNT_W = 4;

  typedef enum logic [1:0] {
    IDLE,   // no mask loaded yet
    RUN,    // accepting input words
    FLUSH,  // draining leftover bytes
    DONE    // flush finished, one cycle
  } ctrl_state_e;

endpackage

/* source/pack_ctrl.sv */
////////////////////////////////////////
// controller FSM for idle, run, flush
////////////////////////////////////////

`timescale 1ns/10ps

module pack_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_in,
  input  logic                       cfg_stb_i,     // mask load, leaves idle
  input  logic                       flush_i,       // one-cycle request
  input  logic                       word_ready_i,  // full word pending in buffer
  input  logic [pack_pkg::CNT_W-1:0] fill_level_i,
  output logic                       accept_o,      // input words are taken
  output logic                       pad_o,         // emit partial word
  output logic                       flush_done_o
);

  pack_pkg::ctrl_state_e state_q;
  pack_pkg::ctrl_state_e state_d;

  always_comb begin
    state_d = state_q;
    pad_o   = 1'b0;
    case (state_q)
      pack_pkg::IDLE: begin
        if (cfg_stb_i) begin
          state_d = pack_pkg::RUN;
        end
      end
      pack_pkg::RUN: begin
        if (flush_i) begin
          state_d = pack_pkg::FLUSH;
        end
      end
      pack_pkg::FLUSH: begin
        // a full word still leaves on its own first
        if (!word_ready_i) begin
          state_d = pack_pkg::DONE;
          if (fill_level_i != '0) begin
            pad_o = 1'b1;  // leftover bytes, padded word
          end
        end
      end
      pack_pkg::DONE: begin
        state_d = pack_pkg::RUN;
      end
      default: begin
        state_d = pack_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state_q <= pack_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign accept_o     = (state_q == pack_pkg::RUN);  // only in run mode
  assign flush_done_o = (state_q == pack_pkg::DONE);

endmodule

/* source/fill_counter.sv */
////////////////////////////////////////
// buffer fill level and full-word flag
////////////////////////////////////////

`timescale 1ns/10ps

module fill_counter (
  input  logic                       clk_i,
  input  logic                       rst_in,
  input  logic [pack_pkg::CNT_W-1:0] add_i,    // bytes appended this cycle
  input  logic                       clear_i,  // padded word drains the rest
  output logic [pack_pkg::CNT_W-1:0] fill_level_o,
  output logic                       word_ready_o
);

  logic [pack_pkg::CNT_W-1:0] fill_q;
  logic [pack_pkg::CNT_W-1:0] fill_d;
  logic [pack_pkg::CNT_W-1:0] sub;

  // a pending full word is consumed at this edge
  always_comb begin
    sub = '0;
    if (word_ready_o) begin
      sub = pack_pkg::CNT_W'(pack_pkg::OUT_BYTES);
    end
    fill_d = fill_q + add_i - sub;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      fill_q <= '0;
    end else if (clear_i) begin
      fill_q <= '0;
    end else begin
      fill_q <= fill_d;
    end
  end

  assign fill_level_o = fill_q;
  assign word_ready_o = (fill_q >= pack_pkg::CNT_W'(pack_pkg::OUT_BYTES));

endmodule

/* source/byte_gather.sv */
////////////////////////////////////////
// lane mask register, lane compaction
// and the byte buffer
////////////////////////////////////////

`timescale 1ns/10ps

module byte_gather (
  input  logic                                 clk_i,
  input  logic                                 rst_in,
  input  logic                                 cfg_stb_i,
  input  logic [pack_pkg::IN_BYTES-1:0]        lane_mask_i,  // set bit drops lane
  input  logic                                 stb_i,
  input  logic                                 accept_i,
  input  logic [pack_pkg::IN_BYTES*8-1:0]      d_i,          // lane 0 oldest
  output logic [pack_pkg::CNT_W-1:0]           add_cnt_o,
  output logic [pack_pkg::BUF_BYTES*8-1:0]     buf_bytes_o   // newest in byte 0
);

  logic [pack_pkg::IN_BYTES-1:0]    mask_q;
  logic [pack_pkg::BUF_BYTES*8-1:0] buf_q;
  logic [pack_pkg::BUF_BYTES*8-1:0] buf_d;
  logic                             take;

  assign take = stb_i & accept_i;

  // new mask applies from the next strobe
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      mask_q <= '0;  // all lanes enabled
    end else if (cfg_stb_i) begin
      mask_q <= lane_mask_i;
    end
  end

  // Bytes enter at the bottom and move up with each new byte, so the
  // oldest held byte sits at index fill_level-1. Anything pushed past the
  // top has already been emitted.
  always_comb begin
    buf_d     = buf_q;
    add_cnt_o = '0;
    if (take) begin
      for (int i = 0; i < pack_pkg::IN_BYTES; i++) begin
        if (!mask_q[i]) begin
          buf_d     = {buf_d[(pack_pkg::BUF_BYTES-1)*8-1:0], d_i[i*8 +: 8]};
          add_cnt_o = add_cnt_o + pack_pkg::CNT_W'(1);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      buf_q <= '0;
    end else begin
      buf_q <= buf_d;
    end
  end

  assign buf_bytes_o = buf_q;

endmodule

/* source/word_emit.sv */
////////////////////////////////////////
// oldest-word select, zero padding and
// the registered output word
////////////////////////////////////////

`timescale 1ns/10ps

module word_emit (
  input  logic                             clk_i,
  input  logic                             rst_in,
  input  logic [pack_pkg::BUF_BYTES*8-1:0] buf_bytes_i,
  input  logic [pack_pkg::CNT_W-1:0]       fill_level_i,
  input  logic                             word_ready_i,
  input  logic                             pad_i,
  output logic                             stb_o,
  output logic [pack_pkg::OUT_BYTES*8-1:0] q_o          // lane 0 oldest
);

  logic [pack_pkg::OUT_BYTES*8-1:0] word_d;
  logic                             emit;

  assign emit = word_ready_i | pad_i;

  // output lane k takes buffer byte fill_level-1-k
  // lanes past the fill level find no byte and stay zero on pad
  always_comb begin
    word_d = '0;
    for (int k = 0; k < pack_pkg::OUT_BYTES; k++) begin
      for (int j = 0; j < pack_pkg::BUF_BYTES; j++) begin
        if (j == int'(fill_level_i) - 1 - k) begin
          word_d[k*8 +: 8] = buf_bytes_i[j*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      stb_o <= 1'b0;
    end else begin
      stb_o <= emit;  // one cycle per word
    end
  end

  always_ff @(posedge clk_i) begin
    if (emit) begin
      q_o <= word_d;
    end
  end

endmodule

/* source/byte_packer.sv */
////////////////////////////////////////
// byte repacker top level
////////////////////////////////////////

`timescale 1ns/10ps

module byte_packer (
  input  logic                             clk_i,
  input  logic                             rst_in,
  input  logic                             cfg_stb_i,
  input  logic [pack_pkg::IN_BYTES-1:0]    lane_mask_i,
  input  logic                             stb_i,
  input  logic [pack_pkg::IN_BYTES*8-1:0]  d_i,
  input  logic                             flush_i,
  output logic                             stb_o,
  output logic [pack_pkg::OUT_BYTES*8-1:0] q_o,
  output logic                             flush_done_o
);

  logic                             accept;
  logic                             pad;
  logic [pack_pkg::CNT_W-1:0]       add_cnt;
  logic [pack_pkg::BUF_BYTES*8-1:0] buf_bytes;
  logic [pack_pkg::CNT_W-1:0]       fill_level;
  logic                             word_ready;

  pack_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_in       (rst_in),
    .cfg_stb_i    (cfg_stb_i),
    .flush_i      (flush_i),
    .word_ready_i (word_ready),
    .fill_level_i (fill_level),
    .accept_o     (accept),
    .pad_o        (pad),
    .flush_done_o (flush_done_o)
  );

  fill_counter u_cnt (
    .clk_i        (clk_i),
    .rst_in       (rst_in),
    .add_i        (add_cnt),
    .clear_i      (pad),  // padded word empties the buffer
    .fill_level_o (fill_level),
    .word_ready_o (word_ready)
  );

  byte_gather u_gather (
    .clk_i       (clk_i),
    .rst_in      (rst_in),
    .cfg_stb_i   (cfg_stb_i),
    .lane_mask_i (lane_mask_i),
    .stb_i       (stb_i),
    .accept_i    (accept),
    .d_i         (d_i),
    .add_cnt_o   (add_cnt),
    .buf_bytes_o (buf_bytes)
  );

  word_emit u_emit (
    .clk_i        (clk_i),
    .rst_in       (rst_in),
    .buf_bytes_i  (buf_bytes),
    .fill_level_i (fill_level),
    .word_ready_i (word_ready),
    .pad_i        (pad),
    .stb_o        (stb_o),
    .q_o          (q_o)
  );

endmodule

/* testbench/byte_packer_props.sv */
////////////////////////////////////////
// bound checks with a byte queue mirror
////////////////////////////////////////

`timescale 1ns/10ps

module byte_packer_props (
  input logic                             clk_i,
  input logic                             rst_in,
  input logic                             cfg_stb_i,
  input logic [pack_pkg::IN_BYTES-1:0]    lane_mask_i,
  input logic                             stb_i,
  input logic [pack_pkg::IN_BYTES*8-1:0]  d_i,
  input logic                             flush_i,
  input logic                             stb_o,
  input logic [pack_pkg::OUT_BYTES*8-1:0] q_o,
  input logic                             flush_done_o,
  input pack_pkg::ctrl_state_e            state_i
);

  logic [7:0]                       bytes_q[$];  // accepted bytes oldest first
  logic [pack_pkg::IN_BYTES-1:0]    mask_m;
  logic                             started;     // first mask seen
  logic                             need_stb;    // full word held so strobe due
  logic [pack_pkg::OUT_BYTES*8-1:0] exp_word;
  int                               flush_wait;  // cycles since flush_i
  int                               err_cnt = 0;

  always @(posedge clk_i) begin
    logic [pack_pkg::OUT_BYTES*8-1:0] head;
    if (!rst_in) begin
      bytes_q.delete();
      mask_m     <= '0;
      started    <= 1'b0;
      need_stb   <= 1'b0;
      exp_word   <= '0;
      flush_wait <= 0;
    end else begin
      if (stb_o) begin  // word just left the DUT
        for (int k = 0; k < pack_pkg::OUT_BYTES; k++) begin
          if (bytes_q.size() > 0) begin
            void'(bytes_q.pop_front());
          end
        end
      end
      need_stb <= (bytes_q.size() >= pack_pkg::OUT_BYTES);
      if (stb_i && started && flush_wait == 0) begin
        for (int i = 0; i < pack_pkg::IN_BYTES; i++) begin
          if (!mask_m[i]) begin
            bytes_q.push_back(d_i[i*8 +: 8]);
          end
        end
      end
      head = '0;
      for (int k = 0; k < pack_pkg::OUT_BYTES; k++) begin
        if (k < bytes_q.size()) begin
          head[k*8 +: 8] = bytes_q[k];  // missing lanes stay zero
        end
      end
      exp_word <= head;
      if (cfg_stb_i) begin
        mask_m  <= lane_mask_i;  // old mask still used this edge
        started <= 1'b1;
      end
      if (flush_done_o) begin
        flush_wait <= 0;
      end else if (flush_wait != 0) begin
        flush_wait <= flush_wait + 1;
      end else if (flush_i && started) begin
        flush_wait <= 1;
      end
    end
  end

  assert property (@(posedge clk_i) !rst_in |=>
                   (!stb_o && !flush_done_o && state_i == pack_pkg::IDLE))
    else begin err_cnt++; $error("outputs or state not idle during reset"); end
  assert property (@(posedge clk_i) disable iff (!rst_in) stb_o |-> q_o == exp_word)
    else begin err_cnt++; $error("ERROR @%0t: q_o differs from mirrored bytes", $time); end
  assert property (@(posedge clk_i) disable iff (!rst_in) need_stb |-> stb_o)
    else begin err_cnt++; $error("no output strobe for a full buffered word"); end
  assert property (@(posedge clk_i) disable iff (!rst_in) flush_wait <= 3)
    else begin err_cnt++; $error("flush_done_o missing 3 cycles after flush_i"); end
  // a full word still held in flush adds one cycle
  assert property (@(posedge clk_i) disable iff (!rst_in)
                   flush_wait == 2 |-> flush_done_o == !need_stb)
    else begin err_cnt++; $error("flush_done_o not two cycles after flush_i"); end
  assert property (@(posedge clk_i) disable iff (!rst_in) flush_done_o |-> flush_wait != 0)
    else begin err_cnt++; $error("flush_done_o without a flush request"); end

endmodule

bind byte_packer byte_packer_props u_props (.*, .state_i(u_ctrl.state_q));

/* testbench/byte_packer_tb.sv */
////////////////////////////////////////
// byte repacker testbench with directed
// and random tests and word counting
////////////////////////////////////////

`timescale 1ns/10ps

module byte_packer_tb;

  localparam int MAX_CYCLES = 2000;  // tests run a few hundred cycles

  logic                             clk_i = 1'b0;
  logic                             rst_in;
  logic                             cfg_stb_i;
  logic [pack_pkg::IN_BYTES-1:0]    lane_mask_i;
  logic                             stb_i;
  logic [pack_pkg::IN_BYTES*8-1:0]  d_i;
  logic                             flush_i;
  logic                             stb_o;
  logic [pack_pkg::OUT_BYTES*8-1:0] q_o;
  logic                             flush_done_o;

  int                            seed = 32'h074cdd0b;
  int                            cycles = 0;
  int                            out_words = 0;
  int                            out_base = 0;
  int                            exp_words = 0;
  int                            pend = 0;  // enabled bytes short of a word
  int                            passes = 0;
  int                            fails = 0;
  int                            asrt_seen = 0;
  logic [pack_pkg::IN_BYTES-1:0] cur_mask = '0;
  logic                          running = 1'b0;  // a mask has been loaded

  byte_packer u_dut (.*);

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (rst_in && stb_o) begin
      out_words <= out_words + 1;
    end
    if (cycles == MAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  task automatic load_mask(input logic [pack_pkg::IN_BYTES-1:0] mask);
    cfg_stb_i   = 1'b1;
    lane_mask_i = mask;
    tick();
    cfg_stb_i = 1'b0;
    cur_mask  = mask;  // applies from the next strobe
    running   = 1'b1;
  endtask

  task automatic send_word(input logic [pack_pkg::IN_BYTES*8-1:0] word);
    stb_i = 1'b1;
    d_i   = word;
    tick();
    stb_i = 1'b0;
    for (int i = 0; i < pack_pkg::IN_BYTES; i++) begin
      if (running && !cur_mask[i]) begin
        pend++;
      end
    end
    if (pend >= pack_pkg::OUT_BYTES) begin
      exp_words++;
      pend -= pack_pkg::OUT_BYTES;
    end
  endtask

  task automatic flush_buffer();
    flush_i = 1'b1;
    tick();
    flush_i = 1'b0;
    if (pend > 0) begin
      exp_words++;  // zero-padded word
    end
    pend = 0;
    while (!flush_done_o) begin
      tick();
    end
    tick();  // back in run mode
  endtask

  task automatic finish_test(input string name);
    int asrt;
    int got;
    repeat (3) tick();  // last word leaves the DUT
    asrt      = u_dut.u_props.err_cnt - asrt_seen;
    asrt_seen = u_dut.u_props.err_cnt;
    got       = out_words - out_base;
    if (got != exp_words) begin
      $display("ERROR @%0t: %s, expected %0d words, got %0d", $time, name, exp_words, got);
    end
    if (got != exp_words || asrt != 0) begin
      fails++;
      $display("%s: failed, %0d assertion failures", name, asrt);
    end else begin
      passes++;
      $display("%s: passed, %0d words", name, got);
    end
    out_base  = out_words;
    exp_words = 0;
  endtask

  initial begin
    logic [31:0] r;
    rst_in      = 1'b0;
    cfg_stb_i   = 1'b0;
    lane_mask_i = '0;
    stb_i       = 1'b0;
    d_i         = '0;
    flush_i     = 1'b0;
    repeat (5) @(posedge clk_i);
    #1 rst_in = 1'b1;

    for (int i = 0; i < 4; i++) begin
      send_word(32'hdead_0000 + i);  // still idle, dropped
    end
    finish_test("idle strobes dropped");

    load_mask(4'b0000);
    for (int i = 0; i < 8; i++) begin
      send_word($random(seed));
    end
    finish_test("all lanes pass through");

    load_mask(4'b1010);  // lanes 1 and 3 dropped
    for (int i = 0; i < 6; i++) begin
      send_word(32'h0302_0100 + 32'h0404_0404 * i);
    end
    finish_test("lanes 1 and 3 dropped");

    send_word(32'h4433_2211);  // two bytes left
    flush_buffer();
    load_mask(4'b1110);
    send_word(32'h0000_0055);  // one byte left
    flush_buffer();
    load_mask(4'b1000);
    send_word(32'h0077_6655);  // three bytes left
    flush_buffer();
    flush_buffer();  // empty buffer
    finish_test("flush with padding");

    for (int n = 0; n < 200; n++) begin
      r = $random(seed);
      if (r[3:0] == 4'h0) begin
        load_mask(r[13:10]);
      end
      if (r[9:5] == 5'h0) begin
        flush_buffer();
      end
      send_word($random(seed));
    end
    flush_buffer();
    finish_test("random stream");

    $display("tests %0d passed, %0d failed, %0d assertion failures", passes, fails, asrt_seen);
    if (fails == 0 && asrt_seen == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
source/pack_pkg.sv
source/pack_ctrl.sv
source/fill_counter.sv
source/byte_gather.sv
source/word_emit.sv
source/byte_packer.sv
testbench/byte_packer_props.sv
testbench/byte_packer_tb.sv

/* Makefile */
# Verilator build and run for the byte repacker
VERILATOR ?= verilator
VFLAGS    := --timing --assert
TOP       := byte_packer_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
